//--- tb.f
+incdir+.
disp_pkg.sv
header_rom.sv
decimal_splitter.sv
display_formatter.sv
tb_display_formatter.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary -j 0 --top-module tb_display_formatter -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_display_formatter.sv
`include "disp_settings.svh"

module tb_display_formatter import disp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RUNS = 40;
    localparam int WATCHDOG_NS = N_RUNS * 7 * 7 * 6 * 5 * 20;

    logic clk = 1'b0;
    logic rst_n;
    logic start_format;
    disp_mode_e display_mode;
    logic [`DISP_ID_W-1:0] matrix_id;
    dim_t dim_m;
    dim_t dim_n;
    elem_t matrix_data;
    logic matrix_data_valid;
    logic tx_busy;
    char_t tx_data;
    logic tx_valid;
    logic data_req;
    logic format_done;

    // owned by the stimulus process
    logic [31:0] stim_lfsr = 32'd71835;
    string exp_str = "";    // expected text of the whole simulation
    int hdr_end = 0;        // stream index just past the current header
    elem_t elems[$];        // every element handed out in request order

    // owned by the uart and data-source process
    logic [31:0] env_lfsr = 32'd71835;
    int rx_idx = 0;
    int req_cnt = 0;
    int done_cnt = 0;

    display_formatter dut (.*);

    always #10 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic int take_bits(inout logic [31:0] st, input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(st[0]);
            st = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
        end
        return v;
    endfunction

    function automatic string header_text(input disp_mode_e mode, input matrix_desc_t desc);
        if (mode == MODE_RESULT)
            return $sformatf("Result (%0dx%0d):\n", desc.rows, desc.cols);
        return $sformatf("Matrix %0d (%0dx%0d):\n", desc.id, desc.rows, desc.cols);
    endfunction

    function automatic string body_text(input matrix_desc_t desc, input int first);
        string s;
        int k;
        s = "";
        k = first;
        for (int r = 0; r < int'(desc.rows); r++) begin
            for (int c = 0; c < int'(desc.cols); c++) begin
                s = {s, $sformatf("%0d", elems[k])};   // sign only when negative
                k++;
                if (c == int'(desc.cols) - 1) s = {s, "\n"};
                else s = {s, " "};
            end
        end
        return {s, "\n"};   // blank line after the matrix
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_char(input char_t got, input char_t exp, input int idx);
        if (got !== exp)
            stop_with_error($sformatf("FAILED at %0d ns: character %0d is 0x%02h, expected 0x%02h",
                                      $time, idx, got, exp));
    endtask

    task automatic check_elem_count(input int got, input dim_t rows, input dim_t cols);
        if (got != int'(rows) * int'(cols))
            stop_with_error($sformatf("FAILED at %0d ns: %0d data requests for a %0dx%0d matrix",
                                      $time, got, rows, cols));
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED at %0d ns: format_done is %b, expected %b",
                                      $time, got, exp));
    endtask

    // uart, data source and stream monitor
    initial begin
        int busy_left;
        int data_wait;
        logic busy_prev;
        logic done_due;
        busy_left = 0;
        data_wait = 0;
        busy_prev = 1'b0;
        done_due = 1'b0;
        tx_busy <= 1'b0;
        matrix_data <= '0;
        matrix_data_valid <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (tx_valid && busy_prev)
                    stop_with_error("tx_valid was raised right after an edge with tx_busy high");
                busy_prev = tx_busy;
                check_done(format_done, done_due);
                done_due = 1'b0;
                if (format_done) done_cnt++;
                if (tx_valid) begin
                    if (rx_idx >= exp_str.len())
                        stop_with_error("the formatter sent a character that was not expected");
                    check_char(tx_data, char_t'(exp_str[rx_idx]), rx_idx);
                    rx_idx++;
                    done_due = (rx_idx == exp_str.len());   // pulse due next cycle
                    busy_left = take_bits(env_lfsr, 2);
                    tx_busy <= (busy_left != 0);
                end else if (busy_left > 0) begin
                    busy_left--;
                    if (busy_left == 0) tx_busy <= 1'b0;
                end
                matrix_data_valid <= 1'b0;
                if (data_req) begin
                    if (req_cnt >= elems.size())
                        stop_with_error("data_req came with no element left to send");
                    if (rx_idx < hdr_end)
                        stop_with_error("data_req came before the header was complete");
                    req_cnt++;
                    data_wait = take_bits(env_lfsr, 2) + 1;
                end else if (data_wait > 0) begin
                    data_wait--;
                    if (data_wait == 0) begin
                        matrix_data <= elems[req_cnt - 1];
                        matrix_data_valid <= 1'b1;
                    end
                end
            end
        end
    end

    task automatic run_format(input disp_mode_e mode, input matrix_desc_t desc);
        int target;
        int first_req;
        target = done_cnt + 1;
        first_req = req_cnt;
        exp_str = {exp_str, header_text(mode, desc)};
        hdr_end = exp_str.len();
        exp_str = {exp_str, body_text(desc, first_req)};
        @(posedge clk);
        start_format <= 1'b1;
        display_mode <= mode;
        matrix_id <= desc.id;
        dim_m <= desc.rows;
        dim_n <= desc.cols;
        @(posedge clk);
        start_format <= 1'b0;
        repeat (3) @(posedge clk);
        start_format <= 1'b1;   // mid-run restart that must be ignored
        dim_m <= 3'd7;
        @(posedge clk);
        start_format <= 1'b0;
        wait (done_cnt == target);
        check_elem_count(req_cnt - first_req, desc.rows, desc.cols);
    endtask

    // unsupported mode produces no output
    task automatic run_ignored(input disp_mode_e mode);
        @(posedge clk);
        start_format <= 1'b1;
        display_mode <= mode;
        @(posedge clk);
        start_format <= 1'b0;
        repeat (40) @(posedge clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_error($sformatf("timeout: the run did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin
        matrix_desc_t desc;
        disp_mode_e mode;
        rst_n <= 1'b0;
        start_format <= 1'b0;
        display_mode <= MODE_MATRIX;
        matrix_id <= '0;
        dim_m <= 3'd1;
        dim_n <= 3'd1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // decimal corner cases first
        elems = '{-8'sd128, -8'sd100, -8'sd10, -8'sd1, 8'sd0,
                  8'sd9, 8'sd10, 8'sd99, 8'sd100, 8'sd127};
        desc.id = 4'd3;
        desc.rows = 3'd2;
        desc.cols = 3'd5;
        run_format(MODE_MATRIX, desc);
        for (int run = 1; run < N_RUNS; run++) begin
            mode = disp_mode_e'(2'(take_bits(stim_lfsr, 2)));
            desc.id = 4'(take_bits(stim_lfsr, 4) % 10);
            desc.rows = 3'(take_bits(stim_lfsr, 3) % 7 + 1);
            desc.cols = 3'(take_bits(stim_lfsr, 3) % 7 + 1);
            if (mode == MODE_MATRIX || mode == MODE_RESULT) begin
                for (int k = 0; k < int'(desc.rows) * int'(desc.cols); k++)
                    elems.push_back(elem_t'(take_bits(stim_lfsr, 8)));
                run_format(mode, desc);
            end else begin
                run_ignored(mode);
            end
        end
        repeat (5) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- display_formatter.sv
`include "disp_settings.svh"

module display_formatter import disp_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic start_format,
    input disp_mode_e display_mode,
    input logic [`DISP_ID_W-1:0] matrix_id,
    input dim_t dim_m,
    input dim_t dim_n,
    input elem_t matrix_data,
    input logic matrix_data_valid,
    input logic tx_busy,
    output char_t tx_data,
    output logic tx_valid,
    output logic data_req,
    output logic format_done
);

    fmt_state_e state;
    elem_phase_e phase;
    elem_phase_e cur_phase;    // first phase at or after phase that prints
    elem_phase_e next_phase;

    logic [`DISP_HDR_IDX_W-1:0] hdr_idx;
    logic [`DISP_HDR_IDX_W-1:0] hdr_len;
    char_t hdr_char;

    dim_t row_cnt;
    dim_t col_cnt;
    logic req_sent;            // data_req issued for the current element

    matrix_desc_t desc_q;
    disp_mode_e mode_q;
    elem_t elem_q;
    digits_t digits;

    logic can_send;
    logic send_fire;
    char_t tx_next;
    logic start_ok;
    logic elem_take;
    logic hdr_last;
    logic row_end;
    logic last_elem;

    function automatic char_t to_ascii(input logic [3:0] d);
        return `DISP_ASCII_ZERO + char_t'(d);
    endfunction

    header_rom u_header (
        .mode(mode_q),
        .desc(desc_q),
        .index(hdr_idx),
        .hdr_char(hdr_char),
        .hdr_len(hdr_len)
    );

    decimal_splitter u_split (
        .value(elem_q),
        .digits(digits)
    );

    // skip the gap cycle after a character so the uart can raise busy
    assign can_send = !tx_busy && !tx_valid;

    assign start_ok = (state == IDLE) && start_format
                    && (display_mode == MODE_MATRIX || display_mode == MODE_RESULT);
    assign elem_take = (state == WAIT_ELEM) && req_sent && matrix_data_valid;

    assign hdr_last = (hdr_idx == hdr_len - 1'b1);
    assign row_end = (col_cnt == desc_q.cols - 1'b1);
    assign last_elem = row_end && (row_cnt == desc_q.rows - 1'b1);

    // hidden digits are skipped in the same cycle
    always_comb begin
        case (phase)
            PH_SIGN: begin
                if (digits.neg) cur_phase = PH_SIGN;
                else if (digits.show_hundreds) cur_phase = PH_HUNDREDS;
                else if (digits.show_tens) cur_phase = PH_TENS;
                else cur_phase = PH_ONES;
            end
            PH_HUNDREDS: begin
                if (digits.show_hundreds) cur_phase = PH_HUNDREDS;
                else if (digits.show_tens) cur_phase = PH_TENS;
                else cur_phase = PH_ONES;
            end
            PH_TENS: cur_phase = digits.show_tens ? PH_TENS : PH_ONES;
            default: cur_phase = phase;
        endcase
    end

    always_comb begin
        case (cur_phase)
            PH_SIGN: next_phase = PH_HUNDREDS;
            PH_HUNDREDS: next_phase = PH_TENS;
            PH_TENS: next_phase = PH_ONES;
            default: next_phase = PH_SEPARATOR;
        endcase
    end

    // character for this cycle, if any
    always_comb begin
        send_fire = 1'b0;
        tx_next = hdr_char;
        case (state)
            SEND_HEADER: send_fire = can_send;
            SEND_ELEM: begin
                send_fire = can_send;
                case (cur_phase)
                    PH_SIGN: tx_next = `DISP_ASCII_MINUS;
                    PH_HUNDREDS: tx_next = to_ascii(digits.hundreds);
                    PH_TENS: tx_next = to_ascii(digits.tens);
                    PH_ONES: tx_next = to_ascii(digits.ones);
                    default: tx_next = row_end ? `DISP_ASCII_NL : `DISP_ASCII_SPACE;
                endcase
            end
            SEND_TAIL: begin
                send_fire = can_send;
                tx_next = `DISP_ASCII_NL;     // blank line after the matrix
            end
            default: send_fire = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            phase <= PH_SIGN;
            hdr_idx <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
            req_sent <= 1'b0;
            tx_valid <= 1'b0;
            data_req <= 1'b0;
            format_done <= 1'b0;
        end else begin
            tx_valid <= send_fire;
            data_req <= 1'b0;
            format_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_ok) begin
                        hdr_idx <= '0;
                        row_cnt <= '0;
                        col_cnt <= '0;
                        req_sent <= 1'b0;
                        state <= SEND_HEADER;
                    end
                end
                SEND_HEADER: begin
                    if (send_fire) begin
                        hdr_idx <= hdr_idx + 1'b1;
                        if (hdr_last) state <= WAIT_ELEM;
                    end
                end
                WAIT_ELEM: begin
                    if (!req_sent) begin
                        data_req <= 1'b1;     // one request per element
                        req_sent <= 1'b1;
                    end else if (matrix_data_valid) begin
                        req_sent <= 1'b0;
                        phase <= PH_SIGN;
                        state <= SEND_ELEM;
                    end
                end
                SEND_ELEM: begin
                    if (send_fire) begin
                        if (cur_phase == PH_SEPARATOR) begin
                            if (last_elem) begin
                                state <= SEND_TAIL;
                            end else begin
                                if (row_end) begin
                                    col_cnt <= '0;
                                    row_cnt <= row_cnt + 1'b1;
                                end else begin
                                    col_cnt <= col_cnt + 1'b1;
                                end
                                state <= WAIT_ELEM;
                            end
                        end else begin
                            phase <= next_phase;
                        end
                    end
                end
                SEND_TAIL: begin
                    if (send_fire) state <= DONE;
                end
                DONE: begin
                    format_done <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            desc_q <= '{id: matrix_id, rows: dim_m, cols: dim_n};
            mode_q <= display_mode;
        end
        if (elem_take) elem_q <= matrix_data;
        if (send_fire) tx_data <= tx_next;
    end

endmodule

//--- decimal_splitter.sv
module decimal_splitter import disp_pkg::*; (
    input elem_t value,
    output digits_t digits
);

    logic signed [8:0] value_x;   // one extra bit so -128 negates cleanly
    logic [8:0] mag;
    logic [3:0] hundreds;
    logic [6:0] rem;              // below 100 after the hundreds step
    logic [3:0] tens;

    assign value_x = value;
    assign mag = value[7] ? 9'(-value_x) : 9'(value_x);

    always_comb begin
        if (mag >= 9'd200) begin
            hundreds = 4'd2;
            rem = 7'(mag - 9'd200);
        end else if (mag >= 9'd100) begin
            hundreds = 4'd1;
            rem = 7'(mag - 9'd100);
        end else begin
            hundreds = 4'd0;
            rem = 7'(mag);
        end
    end

    // comparison ladder where the highest match wins
    always_comb begin
        tens = 4'd0;
        for (int k = 1; k <= 9; k++) begin
            if (rem >= 7'(k * 10)) tens = 4'(k);
        end
    end

    assign digits.hundreds = hundreds;
    assign digits.tens = tens;
    assign digits.ones = 4'(rem - 7'(10 * tens));
    assign digits.neg = value[7];
    assign digits.show_hundreds = (mag >= 9'd100);
    assign digits.show_tens = (mag >= 9'd10);

endmodule

//--- header_rom.sv
`include "disp_settings.svh"

module header_rom import disp_pkg::*; (
    input disp_mode_e mode,
    input matrix_desc_t desc,
    input logic [`DISP_HDR_IDX_W-1:0] index,
    output char_t hdr_char,
    output logic [`DISP_HDR_IDX_W-1:0] hdr_len
);

    localparam int IDX_W = `DISP_HDR_IDX_W;
    localparam int RESULT_LEN = 14;   // "Result (MxN):\n"

    char_t id_char;
    char_t rows_char;
    char_t cols_char;

    assign id_char = `DISP_ASCII_ZERO + char_t'(desc.id);
    assign rows_char = `DISP_ASCII_ZERO + char_t'(desc.rows);
    assign cols_char = `DISP_ASCII_ZERO + char_t'(desc.cols);

    assign hdr_len = (mode == MODE_RESULT) ? IDX_W'(RESULT_LEN) : IDX_W'(`DISP_HDR_MAX);

    always_comb begin
        if (mode == MODE_RESULT) begin
            case (index)
                0: hdr_char = "R";
                1: hdr_char = "e";
                2: hdr_char = "s";
                3: hdr_char = "u";
                4: hdr_char = "l";
                5: hdr_char = "t";
                7: hdr_char = "(";
                8: hdr_char = rows_char;
                9: hdr_char = "x";
                10: hdr_char = cols_char;
                11: hdr_char = ")";
                12: hdr_char = ":";
                13: hdr_char = `DISP_ASCII_NL;
                default: hdr_char = `DISP_ASCII_SPACE;   // also index 6
            endcase
        end else begin
            // matrix mode, "Matrix I (MxN):\n"
            case (index)
                0: hdr_char = "M";
                1: hdr_char = "a";
                2: hdr_char = "t";
                3: hdr_char = "r";
                4: hdr_char = "i";
                5: hdr_char = "x";
                7: hdr_char = id_char;
                9: hdr_char = "(";
                10: hdr_char = rows_char;
                11: hdr_char = "x";
                12: hdr_char = cols_char;
                13: hdr_char = ")";
                14: hdr_char = ":";
                15: hdr_char = `DISP_ASCII_NL;
                default: hdr_char = `DISP_ASCII_SPACE;   // 6 and 8
            endcase
        end
    end

endmodule

//--- disp_pkg.sv
`include "disp_settings.svh"

package disp_pkg;

    typedef logic [`DISP_CHAR_W-1:0] char_t;          // one uart character
    typedef logic [`DISP_DIM_W-1:0] dim_t;            // rows or columns, 1..7
    typedef logic signed [`DISP_ELEM_W-1:0] elem_t;   // matrix element

    // captured at start, feeds the header text
    typedef struct packed {
        logic [`DISP_ID_W-1:0] id;
        dim_t rows;
        dim_t cols;
    } matrix_desc_t;

    typedef enum logic [1:0] {
        MODE_MATRIX = 2'd0,
        MODE_LIST = 2'd1,    // not supported, start is ignored
        MODE_RESULT = 2'd2
    } disp_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        SEND_HEADER,
        WAIT_ELEM,
        SEND_ELEM,
        SEND_TAIL,
        DONE
    } fmt_state_e;

    // order matters, the formatter steps through them in sequence
    typedef enum logic [2:0] {
        PH_SIGN,
        PH_HUNDREDS,
        PH_TENS,
        PH_ONES,
        PH_SEPARATOR
    } elem_phase_e;

    typedef struct packed {
        logic neg;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
        logic show_hundreds;   // magnitude >= 100
        logic show_tens;       // magnitude >= 10
    } digits_t;

endpackage

//--- disp_settings.svh
`ifndef DISP_SETTINGS_SVH
`define DISP_SETTINGS_SVH

// datapath widths
`define DISP_CHAR_W 8
`define DISP_DIM_W 3
`define DISP_ID_W 4
`define DISP_ELEM_W 8

// longest header line, newline included
`define DISP_HDR_MAX 16

// index must also hold the length itself
`define DISP_HDR_IDX_W $clog2(`DISP_HDR_MAX + 1)

// ascii codes shared by rom, formatter and testbench
`define DISP_ASCII_ZERO 8'd48
`define DISP_ASCII_SPACE 8'd32
`define DISP_ASCII_NL 8'd10
`define DISP_ASCII_MINUS 8'd45

`endif
